/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // Base opcodes, instr[6:0]
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // MUL/DIV/REM family under OP

  // Privileged funct12 values, only with funct3 000
  localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
  localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
  localparam logic [11:0] FUNCT12_MRET   = 12'h302;

  // One word, two layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7; // Bit 5 picks SUB/SRA
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] funct12; // CSR address or SYSTEM function
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_t;

endpackage

`default_nettype wire

/* rtl/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

  // ALU operation
  localparam int ALU_OP_W = 4;
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;

  // Write-back mux select
  localparam int WB_SEL_W = 3;
  localparam logic [WB_SEL_W-1:0] WB_ALU = 3'd0;
  localparam logic [WB_SEL_W-1:0] WB_MEM = 3'd1;
  localparam logic [WB_SEL_W-1:0] WB_PC4 = 3'd2; // Link address for JAL/JALR
  localparam logic [WB_SEL_W-1:0] WB_CSR = 3'd3;
  localparam logic [WB_SEL_W-1:0] WB_MUL = 3'd4;

  // Immediate format
  localparam int IMM_SEL_W = 3;
  localparam logic [IMM_SEL_W-1:0] IMM_I = 3'd0;
  localparam logic [IMM_SEL_W-1:0] IMM_S = 3'd1;
  localparam logic [IMM_SEL_W-1:0] IMM_B = 3'd2;
  localparam logic [IMM_SEL_W-1:0] IMM_U = 3'd3;
  localparam logic [IMM_SEL_W-1:0] IMM_J = 3'd4;

  localparam int MULDIV_OP_W = 3; // Straight copy of funct3

endpackage

`default_nettype wire

/* rtl/ctrl_if.sv */
`default_nettype none

interface ctrl_if;
  import ctrl_pkg::*;

  logic                   reg_write;
  logic                   mem_read;
  logic                   mem_write;
  logic                   branch;
  logic                   jump;      // JAL, JALR and MRET
  logic                   alu_src;   // 1 selects immediate
  logic [ALU_OP_W-1:0]    alu_control;
  logic [WB_SEL_W-1:0]    wb_sel;
  logic [IMM_SEL_W-1:0]   imm_sel;
  logic                   csr_we;
  logic                   csr_src;   // 1 selects uimm
  logic                   mul_div_en;
  logic [MULDIV_OP_W-1:0] mul_div_op;
  logic                   illegal_inst;
  logic                   is_ecall;
  logic                   is_ebreak;
  logic                   is_mret;

  // Decode side
  modport source (
    output reg_write, mem_read, mem_write, branch, jump, alu_src,
    output alu_control, wb_sel, imm_sel, csr_we, csr_src, mul_div_en, mul_div_op,
    output illegal_inst, is_ecall, is_ebreak, is_mret
  );

  // Register stage side
  modport sink (
    input reg_write, mem_read, mem_write, branch, jump, alu_src,
    input alu_control, wb_sel, imm_sel, csr_we, csr_src, mul_div_en, mul_div_op,
    input illegal_inst, is_ecall, is_ebreak, is_mret
  );

endinterface

`default_nettype wire

/* rtl/alu_op_decoder.sv */
`default_nettype none

module alu_op_decoder (
  input  logic [2:0]                    funct3,
  input  logic                          funct7_b5,  // instr[30]
  input  logic                          is_reg_op,  // OP rather than OP-IMM
  output logic [ctrl_pkg::ALU_OP_W-1:0] alu_control
);
  import ctrl_pkg::*;

  always_comb begin
    case (funct3)
      3'b000: begin
        // ADDI has no SUB form, instr[30] there is immediate data
        if (is_reg_op && funct7_b5) begin
          alu_control = ALU_SUB;
        end else begin
          alu_control = ALU_ADD;
        end
      end
      3'b001: alu_control = ALU_SLL;
      3'b010: alu_control = ALU_SLT;
      3'b011: alu_control = ALU_SLTU;
      3'b100: alu_control = ALU_XOR;
      3'b101: begin
        // SRAI keeps bit 30 in the shamt field, same rule for both forms
        if (funct7_b5) begin
          alu_control = ALU_SRA;
        end else begin
          alu_control = ALU_SRL;
        end
      end
      3'b110: alu_control = ALU_OR;
      3'b111: alu_control = ALU_AND;
      default: alu_control = ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/system_decoder.sv */
`default_nettype none

module system_decoder (
  input  logic [2:0]  funct3,
  input  logic [11:0] funct12,
  output logic        is_csr,
  output logic        csr_src,    // Immediate form CSRRWI/CSRRSI/CSRRCI
  output logic        is_ecall,
  output logic        is_ebreak,
  output logic        is_mret,
  output logic        sys_illegal
);
  import rv_isa_pkg::*;

  always_comb begin
    is_csr      = 1'b0;
    csr_src     = 1'b0;
    is_ecall    = 1'b0;
    is_ebreak   = 1'b0;
    is_mret     = 1'b0;
    sys_illegal = 1'b0;

    case (funct3)
      3'b000: begin
        // Privileged group, told apart by funct12 alone
        case (funct12)
          FUNCT12_ECALL:  is_ecall  = 1'b1;
          FUNCT12_EBREAK: is_ebreak = 1'b1;
          FUNCT12_MRET:   is_mret   = 1'b1;
          default:        sys_illegal = 1'b1; // SRET, WFI, SFENCE.VMA end up here
        endcase
      end
      3'b100: sys_illegal = 1'b1; // Reserved encoding
      default: begin
        is_csr  = 1'b1;
        csr_src = funct3[2];
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/main_control.sv */
`default_nettype none

module main_control #(
  parameter bit M_EXT_EN = 1'b1
) (
  input  rv_isa_pkg::instr_t instr,
  ctrl_if.source             ctrl
);
  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  logic [ALU_OP_W-1:0] alu_fn;    // funct3/funct7 derived ALU code
  logic                is_reg_op;
  logic                is_muldiv;
  logic                sys_csr;
  logic                sys_csr_src;
  logic                sys_ecall;
  logic                sys_ebreak;
  logic                sys_mret;
  logic                sys_illegal;

  assign is_reg_op = (instr.r.opcode == OP_OP);
  assign is_muldiv = is_reg_op && (instr.r.funct7 == FUNCT7_MULDIV);

  // R view feeds the ALU decode
  alu_op_decoder i_alu_op_decoder (
    .funct3      (instr.r.funct3),
    .funct7_b5   (instr.r.funct7[5]),
    .is_reg_op   (is_reg_op),
    .alu_control (alu_fn)
  );

  // I view feeds the SYSTEM decode
  system_decoder i_system_decoder (
    .funct3      (instr.i.funct3),
    .funct12     (instr.i.funct12),
    .is_csr      (sys_csr),
    .csr_src     (sys_csr_src),
    .is_ecall    (sys_ecall),
    .is_ebreak   (sys_ebreak),
    .is_mret     (sys_mret),
    .sys_illegal (sys_illegal)
  );

  always_comb begin
    // Everything off unless the opcode says otherwise
    ctrl.reg_write    = 1'b0;
    ctrl.mem_read     = 1'b0;
    ctrl.mem_write    = 1'b0;
    ctrl.branch       = 1'b0;
    ctrl.jump         = 1'b0;
    ctrl.alu_src      = 1'b0;
    ctrl.alu_control  = ALU_ADD;
    ctrl.wb_sel       = WB_ALU;
    ctrl.imm_sel      = IMM_I;
    ctrl.csr_we       = 1'b0;
    ctrl.csr_src      = 1'b0;
    ctrl.mul_div_en   = 1'b0;
    ctrl.mul_div_op   = '0;
    ctrl.illegal_inst = 1'b0;
    ctrl.is_ecall     = 1'b0;
    ctrl.is_ebreak    = 1'b0;
    ctrl.is_mret      = 1'b0;

    case (instr.r.opcode)
      OP_LUI, OP_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1; // 0 + imm or pc + imm
        ctrl.imm_sel   = IMM_U;
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.wb_sel    = WB_PC4;
        ctrl.imm_sel   = IMM_J;
      end
      OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump      = 1'b1;
        ctrl.alu_src   = 1'b1; // Target is rs1 + imm
        ctrl.wb_sel    = WB_PC4;
      end
      OP_BRANCH: begin
        ctrl.branch      = 1'b1;
        ctrl.alu_control = ALU_SUB; // Compare rs1 against rs2
        ctrl.imm_sel     = IMM_B;
      end
      OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.wb_sel    = WB_MEM;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.imm_sel   = IMM_S;
      end
      OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src     = 1'b1;
        ctrl.alu_control = alu_fn;
      end
      OP_OP: begin
        if (!is_muldiv) begin
          ctrl.reg_write   = 1'b1;
          ctrl.alu_control = alu_fn;
        end else if (M_EXT_EN) begin
          // ALU idle, M unit result goes to rd
          ctrl.reg_write  = 1'b1;
          ctrl.mul_div_en = 1'b1;
          ctrl.mul_div_op = instr.r.funct3;
          ctrl.wb_sel     = WB_MUL;
        end else begin
          ctrl.illegal_inst = 1'b1; // Core built without M
        end
      end
      OP_FENCE: begin
        // Single hart, in-order memory, nothing to order
        ctrl.illegal_inst = 1'b0;
      end
      OP_SYSTEM: begin
        ctrl.reg_write    = sys_csr;     // Old CSR value to rd
        ctrl.csr_we       = sys_csr;
        ctrl.csr_src      = sys_csr_src;
        ctrl.wb_sel       = sys_csr ? WB_CSR : WB_ALU;
        ctrl.is_ecall     = sys_ecall;
        ctrl.is_ebreak    = sys_ebreak;
        ctrl.is_mret      = sys_mret;
        ctrl.jump         = sys_mret;    // Return to mepc
        ctrl.illegal_inst = sys_illegal;
      end
      default: ctrl.illegal_inst = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/control_stage.sv */
`default_nettype none

module control_stage (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             in_valid,
  output logic                             in_ready,
  ctrl_if.sink                             dec,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic                             reg_write,
  output logic                             mem_read,
  output logic                             mem_write,
  output logic                             branch,
  output logic                             jump,
  output logic                             alu_src,
  output logic [ctrl_pkg::ALU_OP_W-1:0]    alu_control,
  output logic [ctrl_pkg::WB_SEL_W-1:0]    wb_sel,
  output logic [ctrl_pkg::IMM_SEL_W-1:0]   imm_sel,
  output logic                             csr_we,
  output logic                             csr_src,
  output logic                             mul_div_en,
  output logic [ctrl_pkg::MULDIV_OP_W-1:0] mul_div_op,
  output logic                             illegal_inst,
  output logic                             is_ecall,
  output logic                             is_ebreak,
  output logic                             is_mret
);
  import ctrl_pkg::*;

  logic load; // Input side transfer this cycle

  // Free slot, or the held bundle leaves on this edge
  assign in_ready = !out_valid || out_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid; // Drains when nothing new arrives
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      reg_write    <= 1'b0;
      mem_read     <= 1'b0;
      mem_write    <= 1'b0;
      branch       <= 1'b0;
      jump         <= 1'b0;
      alu_src      <= 1'b0;
      alu_control  <= ALU_ADD;
      wb_sel       <= WB_ALU;
      imm_sel      <= IMM_I;
      csr_we       <= 1'b0;
      csr_src      <= 1'b0;
      mul_div_en   <= 1'b0;
      mul_div_op   <= '0;
      illegal_inst <= 1'b0;
      is_ecall     <= 1'b0;
      is_ebreak    <= 1'b0;
      is_mret      <= 1'b0;
    end else if (load) begin
      // Held steady otherwise, stall included
      reg_write    <= dec.reg_write;
      mem_read     <= dec.mem_read;
      mem_write    <= dec.mem_write;
      branch       <= dec.branch;
      jump         <= dec.jump;
      alu_src      <= dec.alu_src;
      alu_control  <= dec.alu_control;
      wb_sel       <= dec.wb_sel;
      imm_sel      <= dec.imm_sel;
      csr_we       <= dec.csr_we;
      csr_src      <= dec.csr_src;
      mul_div_en   <= dec.mul_div_en;
      mul_div_op   <= dec.mul_div_op;
      illegal_inst <= dec.illegal_inst;
      is_ecall     <= dec.is_ecall;
      is_ebreak    <= dec.is_ebreak;
      is_mret      <= dec.is_mret;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv_control_top.sv */
`default_nettype none

module rv_control_top #(
  parameter bit M_EXT_EN = 1'b1 // 0 makes every M instruction illegal
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             in_valid,
  output logic                             in_ready,
  input  logic [31:0]                      instr,
  output logic                             out_valid,
  input  logic                             out_ready,
  output logic                             reg_write,
  output logic                             mem_read,
  output logic                             mem_write,
  output logic                             branch,
  output logic                             jump,
  output logic                             alu_src,
  output logic [ctrl_pkg::ALU_OP_W-1:0]    alu_control,
  output logic [ctrl_pkg::WB_SEL_W-1:0]    wb_sel,
  output logic [ctrl_pkg::IMM_SEL_W-1:0]   imm_sel,
  output logic                             csr_we,
  output logic                             csr_src,
  output logic                             mul_div_en,
  output logic [ctrl_pkg::MULDIV_OP_W-1:0] mul_div_op,
  output logic                             illegal_inst,
  output logic                             is_ecall,
  output logic                             is_ebreak,
  output logic                             is_mret
);

  ctrl_if ctrl_bus (); // Combinational decode result

  main_control #(
    .M_EXT_EN (M_EXT_EN)
  ) i_main_control (
    .instr (instr),
    .ctrl  (ctrl_bus.source)
  );

  // One-entry register stage
  control_stage i_control_stage (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .dec          (ctrl_bus.sink),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .reg_write    (reg_write),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .branch       (branch),
    .jump         (jump),
    .alu_src      (alu_src),
    .alu_control  (alu_control),
    .wb_sel       (wb_sel),
    .imm_sel      (imm_sel),
    .csr_we       (csr_we),
    .csr_src      (csr_src),
    .mul_div_en   (mul_div_en),
    .mul_div_op   (mul_div_op),
    .illegal_inst (illegal_inst),
    .is_ecall     (is_ecall),
    .is_ebreak    (is_ebreak),
    .is_mret      (is_mret)
  );

endmodule

`default_nettype wire

/* bench/control_checker.sv */
`default_nettype none

module control_checker #(
  parameter bit M_EXT_EN = 1'b1,
  parameter int BUNDLE_W = 13 + ctrl_pkg::ALU_OP_W + ctrl_pkg::WB_SEL_W
                         + ctrl_pkg::IMM_SEL_W + ctrl_pkg::MULDIV_OP_W
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  input  logic                in_ready,
  input  logic [31:0]         instr,
  input  logic                out_valid,
  input  logic                out_ready,
  input  logic [BUNDLE_W-1:0] actual,    // Packed DUT outputs
  input  logic [2:0]          test_id,
  input  logic                end_test,  // One-cycle pulse closes test_id
  output int                  pass_cnt,
  output int                  fail_cnt
);
  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  localparam int N_TESTS = 7;

  logic [BUNDLE_W-1:0] exp_q [$];   // Expected bundles in issue order
  logic [31:0]         instr_q [$];
  logic [2:0]          id_q [$];
  int                  checks [N_TESTS];
  int                  errs [N_TESTS];
  int                  n_pass;
  int                  n_fail;
  int                  reset_seen;
  logic                stalled;     // Held output at the previous edge
  logic [BUNDLE_W-1:0] held;
  logic [BUNDLE_W-1:0] exp_bits;
  logic [31:0]         exp_instr;
  logic [2:0]          exp_id;
  logic                exp_ready;

  assign pass_cnt = n_pass;
  assign fail_cnt = n_fail;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0: return "reset";
      3'd1: return "alu_ops";
      3'd2: return "opcodes";
      3'd3: return "muldiv";
      3'd4: return "system";
      3'd5: return "random";
      default: return "backpressure";
    endcase
  endfunction

  // ALU code from funct3 plus the bit 30 overrides
  function automatic logic [ALU_OP_W-1:0] alu_code(input logic [2:0] f3, input logic b5,
                                                   input logic reg_op);
    logic [ALU_OP_W-1:0] base [8];
    base = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
    if (b5 && f3 == 3'd5) return ALU_SRA;         // Both shift forms
    if (b5 && reg_op && f3 == 3'd0) return ALU_SUB; // Register form only
    return base[f3];
  endfunction

  function automatic logic [BUNDLE_W-1:0] expected_ctrl(input logic [31:0] w);
    logic [6:0]             op;
    logic [2:0]             f3;
    logic [6:0]             f7;
    logic [11:0]            f12;
    logic                   rw, rd_mem, wr_mem, br, jmp, imm_src;
    logic                   cwe, csrc, men, ill, ec, eb, mret;
    logic [ALU_OP_W-1:0]    alu;
    logic [WB_SEL_W-1:0]    wb;
    logic [IMM_SEL_W-1:0]   imm;
    logic [MULDIV_OP_W-1:0] md_op;
    op  = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    f12 = w[31:20];
    {rw, rd_mem, wr_mem, br, jmp, imm_src} = '0;
    {cwe, csrc, men, ill, ec, eb, mret} = '0;
    alu   = ALU_ADD;
    wb    = WB_ALU;
    imm   = IMM_I;
    md_op = '0;
    if (op == OP_LUI || op == OP_AUIPC) begin
      {rw, imm_src, imm} = {1'b1, 1'b1, IMM_U};
    end else if (op == OP_JAL) begin
      {rw, jmp, wb, imm} = {1'b1, 1'b1, WB_PC4, IMM_J};
    end else if (op == OP_JALR) begin
      {rw, jmp, imm_src, wb} = {1'b1, 1'b1, 1'b1, WB_PC4};
    end else if (op == OP_BRANCH) begin
      {br, alu, imm} = {1'b1, ALU_SUB, IMM_B};
    end else if (op == OP_LOAD) begin
      {rw, rd_mem, imm_src, wb} = {1'b1, 1'b1, 1'b1, WB_MEM};
    end else if (op == OP_STORE) begin
      {wr_mem, imm_src, imm} = {1'b1, 1'b1, IMM_S};
    end else if (op == OP_IMM) begin
      {rw, imm_src} = 2'b11;
      alu = alu_code(f3, f7[5], 1'b0);
    end else if (op == OP_OP) begin
      if (f7 != FUNCT7_MULDIV) begin
        rw  = 1'b1;
        alu = alu_code(f3, f7[5], 1'b1);
      end else if (!M_EXT_EN) begin
        ill = 1'b1;
      end else begin
        {rw, men, md_op, wb} = {1'b1, 1'b1, f3, WB_MUL};
      end
    end else if (op == OP_SYSTEM) begin
      if (f3 == 3'b000) begin
        ec   = (f12 == FUNCT12_ECALL);
        eb   = (f12 == FUNCT12_EBREAK);
        mret = (f12 == FUNCT12_MRET);
        jmp  = mret; // Back to mepc
        ill  = !(ec || eb || mret);
      end else if (f3 == 3'b100) begin
        ill = 1'b1;
      end else begin
        {cwe, rw, csrc, wb} = {1'b1, 1'b1, f3[2], WB_CSR};
      end
    end else if (op != OP_FENCE) begin
      ill = 1'b1; // FENCE alone falls through as a no-op
    end
    return {rw, rd_mem, wr_mem, br, jmp, imm_src, alu, wb, imm,
            cwe, csrc, men, md_op, ill, ec, eb, mret};
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      if (reset_seen > 0) begin // Registers settle on the first edge
        checks[0]++;
        if (out_valid) begin
          errs[0]++;
          $display("out_valid is high while reset is asserted");
        end
        if (actual !== '0) begin
          errs[0]++;
          $display("error %s expected %h actual %h", test_name(3'd0), {BUNDLE_W{1'b0}}, actual);
        end
      end
      reset_seen++;
      stalled = 1'b0;
    end else begin
      if (out_valid && exp_q.size() == 0) begin
        errs[test_id]++;
        $display("out_valid is high with no instruction outstanding in test %s",
                 test_name(test_id));
      end else if (out_valid && out_ready) begin
        exp_bits  = exp_q.pop_front();
        exp_instr = instr_q.pop_front();
        exp_id    = id_q.pop_front();
        checks[exp_id]++;
        if (actual !== exp_bits) begin
          errs[exp_id]++;
          $display("error %s expected %h actual %h instr %h", test_name(exp_id), exp_bits,
                   actual, exp_instr);
        end
      end
      if (stalled && (!out_valid || actual !== held)) begin
        errs[test_id]++;
        $display("outputs changed while stalled in test %s", test_name(test_id));
      end
      // Input side open unless a held bundle is blocked
      exp_ready = !(out_valid && !out_ready);
      if (in_ready !== exp_ready) begin
        errs[test_id]++;
        $display("error %s expected %b actual %b for in_ready", test_name(test_id), exp_ready,
                 in_ready);
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(expected_ctrl(instr));
        instr_q.push_back(instr);
        id_q.push_back(test_id);
      end
      stalled = out_valid && !out_ready;
      held    = actual;
    end
    if (end_test) begin
      if (checks[test_id] == 0) begin
        n_fail++;
        $display("test %s made no checks at all", test_name(test_id));
      end else if (errs[test_id] != 0) begin
        n_fail++;
        $display("test %-12s FAIL  %0d checks, %0d errors", test_name(test_id),
                 checks[test_id], errs[test_id]);
      end else begin
        n_pass++;
        $display("test %-12s pass  %0d checks", test_name(test_id), checks[test_id]);
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_control.sv */
`default_nettype none

module tb_control;
  import rv_isa_pkg::*;
  import ctrl_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int N_TESTS      = 7;
  localparam int MAX_INSTR    = 400; // About 390 sent over all tests
  localparam int MAX_STALL    = 4;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + MAX_INSTR * (1 + MAX_STALL);
  localparam int BUNDLE_W     = 13 + ALU_OP_W + WB_SEL_W + IMM_SEL_W + MULDIV_OP_W;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   in_valid;
  logic                   in_ready;
  logic [31:0]            instr;
  logic                   out_valid;
  logic                   out_ready = 1'b1;
  logic                   random_ready; // Back-pressure on/off
  logic                   reg_write, mem_read, mem_write, branch, jump, alu_src;
  logic [ALU_OP_W-1:0]    alu_control;
  logic [WB_SEL_W-1:0]    wb_sel;
  logic [IMM_SEL_W-1:0]   imm_sel;
  logic                   csr_we, csr_src, mul_div_en;
  logic [MULDIV_OP_W-1:0] mul_div_op;
  logic                   illegal_inst, is_ecall, is_ebreak, is_mret;
  logic [BUNDLE_W-1:0]    actual;
  logic [2:0]             test_id;
  logic                   end_test;
  int                     pass_cnt;
  int                     fail_cnt;
  int                     seed = 9311;
  int                     cycles = 0;

  always #2 clk = ~clk;

  rv_control_top #(
    .M_EXT_EN (1'b1)
  ) i_dut (
    .clk (clk), .reset (reset), .in_valid (in_valid), .in_ready (in_ready),
    .instr (instr), .out_valid (out_valid), .out_ready (out_ready),
    .reg_write (reg_write), .mem_read (mem_read), .mem_write (mem_write),
    .branch (branch), .jump (jump), .alu_src (alu_src), .alu_control (alu_control),
    .wb_sel (wb_sel), .imm_sel (imm_sel), .csr_we (csr_we), .csr_src (csr_src),
    .mul_div_en (mul_div_en), .mul_div_op (mul_div_op), .illegal_inst (illegal_inst),
    .is_ecall (is_ecall), .is_ebreak (is_ebreak), .is_mret (is_mret)
  );

  // Same field order as the checker's reference
  assign actual = {reg_write, mem_read, mem_write, branch, jump, alu_src, alu_control, wb_sel,
                   imm_sel, csr_we, csr_src, mul_div_en, mul_div_op, illegal_inst, is_ecall,
                   is_ebreak, is_mret};

  control_checker #(
    .M_EXT_EN (1'b1)
  ) i_checker (
    .clk (clk), .reset (reset), .in_valid (in_valid), .in_ready (in_ready), .instr (instr),
    .out_valid (out_valid), .out_ready (out_ready), .actual (actual), .test_id (test_id),
    .end_test (end_test), .pass_cnt (pass_cnt), .fail_cnt (fail_cnt)
  );

  always @(posedge clk) begin
    if (random_ready) begin
      out_ready <= ($random(seed) & 3) != 0; // Roughly one stall in four
    end else begin
      out_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped moving instructions", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] make_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] op);
    return {f7, 5'd3, 5'd2, f3, 5'd1, op};
  endfunction

  function automatic logic [31:0] make_i(input logic [11:0] f12, input logic [2:0] f3,
                                         input logic [6:0] op);
    return {f12, 5'd2, f3, 5'd1, op};
  endfunction

  // Steers random words toward real opcodes
  function automatic logic [6:0] pick_opcode(input logic [3:0] k);
    case (k)
      4'd0: return OP_LUI;
      4'd1: return OP_AUIPC;
      4'd2: return OP_JAL;
      4'd3: return OP_JALR;
      4'd4: return OP_BRANCH;
      4'd5: return OP_LOAD;
      4'd6: return OP_STORE;
      4'd7: return OP_IMM;
      4'd8: return OP_FENCE;
      4'd9: return OP_SYSTEM;
      default: return OP_OP;
    endcase
  endfunction

  task automatic send(input logic [31:0] w);
    in_valid <= 1'b1;
    instr    <= w;
    @(posedge clk);
    while (!in_ready) begin // Held until accepted
      @(posedge clk);
    end
  endtask

  // Drain the stage, then let the checker close the test
  task automatic finish_test;
    in_valid <= 1'b0;
    @(posedge clk);
    while (out_valid) begin
      @(posedge clk);
    end
    end_test <= 1'b1;
    @(posedge clk);
    end_test <= 1'b0;
  endtask

  initial begin
    logic [31:0] w;
    reset        <= 1'b1;
    in_valid     <= 1'b0;
    instr        <= '0;
    test_id      <= 3'd0;
    end_test     <= 1'b0;
    random_ready <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk); // Idle, out_valid must stay low
    finish_test();

    test_id <= 3'd1;
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int b5 = 0; b5 < 2; b5++) begin
        send(make_r({1'b0, b5[0], 5'b0}, f3[2:0], OP_OP));
        send(make_i({1'b0, b5[0], 10'h015}, f3[2:0], OP_IMM));
      end
    end
    finish_test();

    test_id <= 3'd2;
    send(make_i(12'h812, 3'b000, OP_LUI));
    send(make_i(12'h004, 3'b000, OP_AUIPC));
    send(make_i(12'h7fe, 3'b000, OP_JAL));
    send(make_i(12'h010, 3'b000, OP_JALR));
    for (int f3 = 0; f3 < 8; f3++) begin
      send(make_r(7'h3f, f3[2:0], OP_BRANCH));
    end
    send(make_i(12'h020, 3'b010, OP_LOAD));
    send(make_i(12'hffc, 3'b100, OP_LOAD));
    send(make_r(7'h01, 3'b010, OP_STORE));
    send(make_r(7'h00, 3'b000, OP_STORE));
    send(make_i(12'h0ff, 3'b000, OP_FENCE));
    finish_test();

    test_id <= 3'd3;
    for (int f3 = 0; f3 < 8; f3++) begin
      send(make_r(FUNCT7_MULDIV, f3[2:0], OP_OP));
    end
    finish_test();

    test_id <= 3'd4;
    for (int f3 = 1; f3 < 8; f3++) begin
      send(make_i(12'h341, f3[2:0], OP_SYSTEM)); // funct3 100 is reserved
    end
    send(make_i(FUNCT12_ECALL, 3'b000, OP_SYSTEM));
    send(make_i(FUNCT12_EBREAK, 3'b000, OP_SYSTEM));
    send(make_i(FUNCT12_MRET, 3'b000, OP_SYSTEM));
    send(make_i(12'h102, 3'b000, OP_SYSTEM)); // SRET
    send(make_i(12'h105, 3'b000, OP_SYSTEM)); // WFI
    finish_test();

    test_id <= 3'd5;
    for (int n = 0; n < 200; n++) begin
      w = $random(seed);
      if (w[31]) w[6:0] = pick_opcode(w[10:7]);
      send(w);
    end
    finish_test();

    test_id      <= 3'd6;
    random_ready <= 1'b1;
    for (int n = 0; n < 120; n++) begin
      w = $random(seed);
      w[6:0] = pick_opcode(w[10:7]);
      send(w);
    end
    finish_test();
    random_ready <= 1'b0;

    repeat (2) @(posedge clk);
    $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == N_TESTS) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
rtl/rv_isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/ctrl_if.sv
rtl/alu_op_decoder.sv
rtl/system_decoder.sv
rtl/main_control.sv
rtl/control_stage.sv
rtl/rv_control_top.sv
bench/control_checker.sv
bench/tb_control.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_control -f all.f --Mdir obj_dir -o tb_control \
  && ./obj_dir/tb_control | tee sim.log \
  || echo "build or simulation did not complete"
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
